//--- verilog/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // Widths with a meaning
    typedef logic [31:0] instr_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  bp_tag_t;     // Opaque, owned by the predictor
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  fn3_t;

    localparam int FETCH_BUFFER_DEPTH = 4;

    ////////////////////////////////////////
    // Opcode groups, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        AMO_T       = 5'b01011,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_group_t;

    // Funct3 for ALU ops
    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3     = 3'b001;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    localparam fn3_t XOR_FN3     = 3'b100;
    localparam fn3_t SRA_FN3     = 3'b101;  // SRL shares it
    localparam fn3_t OR_FN3      = 3'b110;
    localparam fn3_t AND_FN3     = 3'b111;

    ////////////////////////////////////////
    // ALU control encodings
    typedef enum logic [1:0] {
        ALU_ADD_SUB = 2'b00,
        ALU_SLT     = 2'b01,
        ALU_LSHIFT  = 2'b10,
        ALU_RSHIFT  = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

    typedef enum logic [1:0] {
        ALU_RS1_ZERO = 2'b00,
        ALU_RS1_PC   = 2'b01,
        ALU_RS1_RF   = 2'b10
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_LUI_AUIPC = 2'b00,
        ALU_RS2_ARITH_IMM = 2'b01,
        ALU_RS2_JAL_JALR  = 2'b10,
        ALU_RS2_RF        = 2'b11
    } alu_rs2_sel_t;

    // One fetched word plus its predecoded hints
    typedef struct packed {
        instr_t        instruction;
        addr_t         pc;
        bp_tag_t       bp_tag;
        logic          prediction_used;
        logic          is_call;
        logic          is_return;
        logic          uses_rs1;
        logic          uses_rs2;
        logic          uses_rd;
        logic          rd_zero;
        logic          alu_request;
        logic          alu_sub;
        alu_op_t       alu_op;
        alu_logic_op_t alu_logic_op;
        alu_rs1_sel_t  alu_rs1_sel;
        alu_rs2_sel_t  alu_rs2_sel;
    } fetch_packet_t;

endpackage

//--- verilog/fifo_if.sv
interface fifo_if;
    import fetch_pkg::*;

    logic          push;
    logic          pop;
    fetch_packet_t data_in;
    fetch_packet_t data_out;   // Always the head entry
    logic          valid;
    logic          empty;
    logic          full;

    // Side that pushes and pops
    modport owner (
        output push,
        output pop,
        output data_in,
        input  data_out,
        input  valid,
        input  empty,
        input  full
    );

    // Memory block
    modport storage (
        input  push,
        input  pop,
        input  data_in,
        output data_out,
        output valid,
        output empty,
        output full
    );

endinterface

//--- verilog/lutram_fifo.sv
module lutram_fifo #(
    parameter int DEPTH = 4
) (
    input logic     clk,
    input logic     clear,
    fifo_if.storage fifo
);
    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    fetch_packet_t mem [DEPTH];
    ptr_t          wr_ptr;
    ptr_t          rd_ptr;
    count_t        count;
    logic          write_en;
    logic          read_en;

    // Wraps at DEPTH, so odd depths work too
    function automatic ptr_t next_ptr(input ptr_t ptr);
        ptr_t result;
        if (ptr == ptr_t'(DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign write_en = fifo.push & ~fifo.full;    // Dropped when full
    assign read_en  = fifo.pop & ~fifo.empty;

    ////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[wr_ptr] <= fifo.data_in;
        end
    end

    assign fifo.data_out = mem[rd_ptr];

    ////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (write_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (read_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({write_en, read_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    assign fifo.empty = (count == '0);
    assign fifo.full  = (count == count_t'(DEPTH));
    assign fifo.valid = ~fifo.empty;

endmodule

//--- verilog/instruction_predecoder.sv
module instruction_predecoder (
    input  fetch_pkg::instr_t        instruction,
    input  fetch_pkg::addr_t         pc,
    input  fetch_pkg::bp_tag_t       bp_tag,
    input  logic                     prediction_used,
    output fetch_pkg::fetch_packet_t packet
);
    import fetch_pkg::*;

    opcode_group_t opcode_group;
    fn3_t          fn3;
    reg_addr_t     rs1_addr;
    reg_addr_t     rd_addr;

    logic jal_jalr;
    logic jal_jalr_x0;
    logic non_zero_jal_jalr;
    logic csr_imm_op;
    logic sys_op;
    logic rs1_link;
    logic rd_link;
    logic arith_sub;
    logic base_arith;

    alu_op_t       alu_op;
    alu_logic_op_t alu_logic_op;
    alu_rs1_sel_t  rs1_sel;
    alu_rs2_sel_t  rs2_sel;

    ////////////////////////////////////////
    // Field extraction
    assign opcode_group = opcode_group_t'(instruction[6:2]);
    assign fn3          = instruction[14:12];
    assign rs1_addr     = instruction[19:15];
    assign rd_addr      = instruction[11:7];

    assign jal_jalr          = opcode_group inside {JAL_T, JALR_T};
    assign jal_jalr_x0       = jal_jalr && (rd_addr == '0);
    assign non_zero_jal_jalr = jal_jalr && (rd_addr != '0);
    assign csr_imm_op        = (opcode_group == SYSTEM_T) && fn3[2];
    assign sys_op            = (opcode_group == SYSTEM_T) && (fn3 == 3'b000);  // ECALL, EBREAK, xRET

    // x1 and x5 are the link registers
    assign rs1_link = rs1_addr inside {5'd1, 5'd5};
    assign rd_link  = rd_addr inside {5'd1, 5'd5};

    ////////////////////////////////////////
    // ALU control
    assign arith_sub  = (fn3 == ADD_SUB_FN3) && instruction[30] && instruction[5];
    assign base_arith = (opcode_group == ARITH_T) && ~instruction[25];  // Bit 25 marks mul/div

    always_comb begin
        alu_op       = ALU_ADD_SUB;
        alu_logic_op = ALU_LOGIC_ADD;
        case (fn3)
            ADD_SUB_FN3:       alu_op = ALU_ADD_SUB;
            SLT_FN3, SLTU_FN3: alu_op = ALU_SLT;
            SLL_FN3:           alu_op = ALU_LSHIFT;
            SRA_FN3:           alu_op = ALU_RSHIFT;
            XOR_FN3:           alu_logic_op = ALU_LOGIC_XOR;
            OR_FN3:            alu_logic_op = ALU_LOGIC_OR;
            AND_FN3:           alu_logic_op = ALU_LOGIC_AND;
            default:           alu_op = ALU_ADD_SUB;
        endcase
        // LUI, AUIPC, JAL and JALR all go through the adder
        if (instruction[2]) begin
            alu_op       = ALU_ADD_SUB;
            alu_logic_op = ALU_LOGIC_ADD;
        end
    end

    always_comb begin
        if (opcode_group inside {ARITH_T, ARITH_IMM_T}) begin
            rs1_sel = ALU_RS1_RF;
        end else if (opcode_group inside {JAL_T, JALR_T, AUIPC_T}) begin
            rs1_sel = ALU_RS1_PC;
        end else begin
            rs1_sel = ALU_RS1_ZERO;   // LUI
        end
    end

    always_comb begin
        if (opcode_group inside {LUI_T, AUIPC_T}) begin
            rs2_sel = ALU_RS2_LUI_AUIPC;
        end else if (opcode_group == ARITH_IMM_T) begin
            rs2_sel = ALU_RS2_ARITH_IMM;
        end else if (non_zero_jal_jalr) begin
            rs2_sel = ALU_RS2_JAL_JALR;  // Link value pc + 4
        end else begin
            rs2_sel = ALU_RS2_RF;
        end
    end

    ////////////////////////////////////////
    // Packet assembly
    always_comb begin
        packet.instruction     = instruction;
        packet.pc              = pc;
        packet.bp_tag          = bp_tag;
        packet.prediction_used = prediction_used;
        packet.is_call         = jal_jalr && rd_link;
        packet.is_return       = (opcode_group == JALR_T) &&
                                 ((rs1_link & ~rd_link) | (rs1_link & rd_link & (rs1_addr != rd_addr)));
        packet.uses_rs1        = !((opcode_group inside {LUI_T, AUIPC_T, JAL_T, FENCE_T}) ||
                                   csr_imm_op || sys_op);
        packet.uses_rs2        = opcode_group inside {BRANCH_T, STORE_T, ARITH_T, AMO_T};
        packet.uses_rd         = !((opcode_group inside {BRANCH_T, STORE_T, FENCE_T}) ||
                                   sys_op || jal_jalr_x0);
        packet.rd_zero         = (rd_addr == '0);
        packet.alu_request     = base_arith || non_zero_jal_jalr ||
                                 (opcode_group inside {ARITH_IMM_T, AUIPC_T, LUI_T});
        packet.alu_sub         = ~instruction[2] & ((fn3 inside {SLT_FN3, SLTU_FN3}) || arith_sub);
        packet.alu_op          = alu_op;
        packet.alu_logic_op    = alu_logic_op;
        packet.alu_rs1_sel     = rs1_sel;
        packet.alu_rs2_sel     = rs2_sel;
    end

endmodule

//--- verilog/pre_decode.sv
module pre_decode #(
    parameter int FIFO_DEPTH = fetch_pkg::FETCH_BUFFER_DEPTH
) (
    input  logic                     clk,
    input  logic                     buffer_reset,
    input  logic                     flush,
    input  logic                     push,
    input  logic                     pop,
    input  fetch_pkg::instr_t        instruction,
    input  fetch_pkg::addr_t         pc,
    input  fetch_pkg::bp_tag_t       bp_tag,
    input  logic                     prediction_used,
    output logic                     fb_valid,
    output fetch_pkg::fetch_packet_t fb,
    output logic                     fb_full
);
    import fetch_pkg::*;

    fetch_packet_t packet;
    logic          fifo_clear;
    logic          bypass;

    fifo_if fb_fifo ();

    instruction_predecoder u_predecoder (
        .instruction     (instruction),
        .pc              (pc),
        .bp_tag          (bp_tag),
        .prediction_used (prediction_used),
        .packet          (packet)
    );

    ////////////////////////////////////////
    // Queue control
    assign fifo_clear = buffer_reset | flush;

    // Skip the FIFO when nothing is ahead of the new word
    assign bypass = fb_fifo.empty & (~fb_valid | pop);

    assign fb_fifo.push    = push & ~bypass;
    assign fb_fifo.pop     = pop & fb_fifo.valid;
    assign fb_fifo.data_in = packet;
    assign fb_full         = fb_fifo.full;

    lutram_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .clear (fifo_clear),
        .fifo  (fb_fifo.storage)
    );

    ////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (push & bypass) begin
            fb <= packet;
        end else if (pop) begin
            fb <= fb_fifo.data_out;   // Next in line
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_clear) begin
            fb_valid <= 1'b0;
        end else if (push) begin
            fb_valid <= 1'b1;
        end else if (pop & fb_fifo.empty) begin
            fb_valid <= 1'b0;         // Last packet taken
        end
    end

    ////////////////////////////////////////
    // Checks on fetch and decode behaviour
    a_no_strobe_in_flush : assert property (@(posedge clk) disable iff (buffer_reset)
        flush |-> !(push || pop))
        else $error("fetch buffer push or pop during flush");

    a_no_push_when_full : assert property (@(posedge clk) disable iff (buffer_reset)
        fb_full |-> !push)
        else $error("fetch buffer push while full");

    a_no_pop_when_empty : assert property (@(posedge clk) disable iff (buffer_reset)
        !fb_valid |-> !pop)
        else $error("fetch buffer pop without a valid packet");

endmodule

//--- verilog/fetch_buffer_top.sv
module fetch_buffer_top #(
    parameter int FETCH_BUFFER_DEPTH = fetch_pkg::FETCH_BUFFER_DEPTH
) (
    input  logic                     clk,
    input  logic                     buffer_reset,

    // Fetch
    input  fetch_pkg::instr_t        instruction,
    input  fetch_pkg::addr_t         pc,
    input  fetch_pkg::bp_tag_t       bp_tag,
    input  logic                     prediction_used,
    input  logic                     push,

    // Global control
    input  logic                     flush,

    // Decode
    input  logic                     pop,
    output logic                     fb_valid,
    output fetch_pkg::fetch_packet_t fb,
    output logic                     fb_full    // Fetch stalls on this
);

    ////////////////////////////////////////
    // Fetch buffer, holds DEPTH + 1 packets
    pre_decode #(
        .FIFO_DEPTH (FETCH_BUFFER_DEPTH)
    ) u_pre_decode (
        .clk             (clk),
        .buffer_reset    (buffer_reset),
        .flush           (flush),
        .push            (push),
        .pop             (pop),
        .instruction     (instruction),
        .pc              (pc),
        .bp_tag          (bp_tag),
        .prediction_used (prediction_used),
        .fb_valid        (fb_valid),
        .fb              (fb),
        .fb_full         (fb_full)
    );

endmodule

//--- include/predecode_model.svh
`ifndef PREDECODE_MODEL_SVH
`define PREDECODE_MODEL_SVH

// x1 or x5
function automatic logic model_is_link(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
endfunction

// Expected packet for one fetched word
function automatic fetch_pkg::fetch_packet_t model_predecode(
    input fetch_pkg::instr_t  instr,
    input fetch_pkg::addr_t   pc,
    input fetch_pkg::bp_tag_t tag,
    input logic               pred_used
);
    fetch_pkg::fetch_packet_t p;
    logic [4:0] op;
    logic [2:0] fn3;
    logic [4:0] rs1;
    logic [4:0] rd;
    logic       jump;
    logic       sys_fn0;
    op      = instr[6:2];
    fn3     = instr[14:12];
    rs1     = instr[19:15];
    rd      = instr[11:7];
    jump    = (op == fetch_pkg::JAL_T) || (op == fetch_pkg::JALR_T);
    sys_fn0 = (op == fetch_pkg::SYSTEM_T) && (fn3 == 3'b000);

    p.instruction     = instr;
    p.pc              = pc;
    p.bp_tag          = tag;
    p.prediction_used = pred_used;
    p.is_call         = jump && model_is_link(rd);
    p.is_return       = (op == fetch_pkg::JALR_T) && model_is_link(rs1) &&
                        (!model_is_link(rd) || (rs1 != rd));
    p.uses_rs1        = !((op inside {fetch_pkg::LUI_T, fetch_pkg::AUIPC_T, fetch_pkg::JAL_T,
                                      fetch_pkg::FENCE_T}) ||
                          ((op == fetch_pkg::SYSTEM_T) && fn3[2]) || sys_fn0);
    p.uses_rs2        = op inside {fetch_pkg::BRANCH_T, fetch_pkg::STORE_T, fetch_pkg::ARITH_T,
                                   fetch_pkg::AMO_T};
    p.uses_rd         = !((op inside {fetch_pkg::BRANCH_T, fetch_pkg::STORE_T,
                                      fetch_pkg::FENCE_T}) || sys_fn0 || (jump && (rd == 0)));
    p.rd_zero         = (rd == 0);
    p.alu_request     = ((op == fetch_pkg::ARITH_T) && !instr[25]) || (jump && (rd != 0)) ||
                        (op inside {fetch_pkg::ARITH_IMM_T, fetch_pkg::AUIPC_T, fetch_pkg::LUI_T});
    p.alu_sub         = !instr[2] && ((fn3 inside {fetch_pkg::SLT_FN3, fetch_pkg::SLTU_FN3}) ||
                        ((fn3 == fetch_pkg::ADD_SUB_FN3) && instr[30] && instr[5]));

    case (fn3)
        fetch_pkg::SLT_FN3, fetch_pkg::SLTU_FN3: p.alu_op = fetch_pkg::ALU_SLT;
        fetch_pkg::SLL_FN3:                      p.alu_op = fetch_pkg::ALU_LSHIFT;
        fetch_pkg::SRA_FN3:                      p.alu_op = fetch_pkg::ALU_RSHIFT;
        default:                                 p.alu_op = fetch_pkg::ALU_ADD_SUB;
    endcase
    case (fn3)
        fetch_pkg::XOR_FN3: p.alu_logic_op = fetch_pkg::ALU_LOGIC_XOR;
        fetch_pkg::OR_FN3:  p.alu_logic_op = fetch_pkg::ALU_LOGIC_OR;
        fetch_pkg::AND_FN3: p.alu_logic_op = fetch_pkg::ALU_LOGIC_AND;
        default:            p.alu_logic_op = fetch_pkg::ALU_LOGIC_ADD;
    endcase
    if (instr[2]) begin
        p.alu_op       = fetch_pkg::ALU_ADD_SUB;
        p.alu_logic_op = fetch_pkg::ALU_LOGIC_ADD;
    end

    if (op inside {fetch_pkg::ARITH_T, fetch_pkg::ARITH_IMM_T}) begin
        p.alu_rs1_sel = fetch_pkg::ALU_RS1_RF;
    end else if (jump || (op == fetch_pkg::AUIPC_T)) begin
        p.alu_rs1_sel = fetch_pkg::ALU_RS1_PC;
    end else begin
        p.alu_rs1_sel = fetch_pkg::ALU_RS1_ZERO;
    end

    if (op inside {fetch_pkg::LUI_T, fetch_pkg::AUIPC_T}) begin
        p.alu_rs2_sel = fetch_pkg::ALU_RS2_LUI_AUIPC;
    end else if (op == fetch_pkg::ARITH_IMM_T) begin
        p.alu_rs2_sel = fetch_pkg::ALU_RS2_ARITH_IMM;
    end else if (jump && (rd != 0)) begin
        p.alu_rs2_sel = fetch_pkg::ALU_RS2_JAL_JALR;
    end else begin
        p.alu_rs2_sel = fetch_pkg::ALU_RS2_RF;
    end
    return p;
endfunction

`endif

//--- test/tb_fetch_buffer.sv
module tb_fetch_buffer;
    import fetch_pkg::*;

    `include "predecode_model.svh"

    logic          clk;
    logic          buffer_reset;
    instr_t        instruction;
    addr_t         pc;
    bp_tag_t       bp_tag;
    logic          prediction_used;
    logic          push;
    logic          flush;
    logic          pop;
    logic          fb_valid;
    fetch_packet_t fb;
    logic          fb_full;

    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    logic [31:0]   rng_state = 32'd13;
    fetch_packet_t exp_q [$];     // Expected packets in push order

    opcode_group_t groups [12] = '{LUI_T, AUIPC_T, JAL_T, JALR_T, BRANCH_T, LOAD_T,
                                   STORE_T, ARITH_IMM_T, ARITH_T, FENCE_T, AMO_T, SYSTEM_T};

    fetch_buffer_top u_dut (
        .clk             (clk),
        .buffer_reset    (buffer_reset),
        .instruction     (instruction),
        .pc              (pc),
        .bp_tag          (bp_tag),
        .prediction_used (prediction_used),
        .push            (push),
        .flush           (flush),
        .pop             (pop),
        .fb_valid        (fb_valid),
        .fb              (fb),
        .fb_full         (fb_full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Random word of a random group, biased toward link registers
    function automatic instr_t random_word();
        logic [31:0] r;
        instr_t      w;
        r = next_random();
        w = next_random();
        w[6:2] = groups[r % 12];
        w[1:0] = 2'b11;
        if (r[5:4] == 2'b00) begin
            w[11:7] = r[8] ? 5'd5 : 5'd1;
        end else if (r[5:4] == 2'b01) begin
            w[11:7] = 5'd0;
        end
        if (r[9]) begin
            w[19:15] = r[10] ? 5'd5 : 5'd1;
        end
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;                            // Drive and sample after the edge settles
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_packet(input fetch_packet_t exp);
        check_field("fb_valid", 32'd1, fb_valid);
        check_field("fb.instruction", exp.instruction, fb.instruction);
        check_field("fb.pc", exp.pc, fb.pc);
        check_field("fb.bp_tag", exp.bp_tag, fb.bp_tag);
        check_field("fb.prediction_used", exp.prediction_used, fb.prediction_used);
        check_field("fb hint and use flags",
            {exp.is_call, exp.is_return, exp.uses_rs1, exp.uses_rs2, exp.uses_rd,
             exp.rd_zero, exp.alu_request, exp.alu_sub},
            {fb.is_call, fb.is_return, fb.uses_rs1, fb.uses_rs2, fb.uses_rd,
             fb.rd_zero, fb.alu_request, fb.alu_sub});
        check_field("fb alu controls",
            {exp.alu_op, exp.alu_logic_op, exp.alu_rs1_sel, exp.alu_rs2_sel},
            {fb.alu_op, fb.alu_logic_op, fb.alu_rs1_sel, fb.alu_rs2_sel});
    endtask

    // Sets up one fetch word with push high, expected packet queued
    task automatic drive_word(input instr_t word);
        logic [31:0] r;
        r = next_random();
        instruction     = word;
        pc              = {r[31:2], 2'b00};
        bp_tag          = r[9:2];
        prediction_used = r[0];
        push            = 1'b1;
        exp_q.push_back(model_predecode(word, pc, bp_tag, prediction_used));
    endtask

    task automatic pop_one();
        pop = 1'b1;
        tick();
        pop = 1'b0;
    endtask

    task automatic wait_valid(input string where);
        int cycles;
        cycles = 0;
        while (fb_valid !== 1'b1 && cycles < 20) begin
            tick();
            cycles++;
        end
        if (fb_valid !== 1'b1) begin
            $display("ERROR t=%0t timeout waiting for fb_valid in %s", $time, where);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    task automatic test_reset();
        int errs;
        errs = errors;
        check_field("fb_valid", 32'd0, fb_valid);
        check_field("fb_full", 32'd0, fb_full);
        finish_test("reset", errs);
    endtask

    task automatic test_single_push();
        int errs;
        errs = errors;
        exp_q.delete();
        drive_word(random_word());
        tick();
        push = 1'b0;
        check_packet(exp_q.pop_front());   // Exactly one edge on the bypass
        pop_one();
        check_field("fb_valid", 32'd0, fb_valid);
        finish_test("single_push", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = errors;
        exp_q.delete();
        repeat (FETCH_BUFFER_DEPTH + 1) begin
            drive_word(random_word());
            tick();
        end
        push = 1'b0;
        check_field("fb_full", 32'd1, fb_full);
        for (int i = 0; i <= FETCH_BUFFER_DEPTH; i++) begin
            wait_valid("back_pressure");
            check_packet(exp_q.pop_front());
            if (fb_valid === 1'b1) begin
                pop_one();
            end
        end
        check_field("fb_valid", 32'd0, fb_valid);
        check_field("fb_full", 32'd0, fb_full);
        finish_test("back_pressure", errs);
    endtask

    task automatic test_push_pop_bypass();
        int errs;
        errs = errors;
        exp_q.delete();
        drive_word(random_word());
        tick();
        push = 1'b0;
        check_packet(exp_q.pop_front());
        drive_word(random_word());
        pop = 1'b1;                        // Same cycle as the push
        tick();
        push = 1'b0;
        pop  = 1'b0;
        check_packet(exp_q.pop_front());
        pop_one();
        check_field("fb_valid", 32'd0, fb_valid);
        finish_test("push_pop_bypass", errs);
    endtask

    task automatic test_flush();
        int errs;
        errs = errors;
        exp_q.delete();
        repeat (FETCH_BUFFER_DEPTH + 1) begin
            drive_word(random_word());
            tick();
        end
        push = 1'b0;
        check_field("fb_full", 32'd1, fb_full);
        exp_q.delete();                    // Redirect drops all of them
        flush = 1'b1;
        tick();
        flush = 1'b0;
        check_field("fb_valid", 32'd0, fb_valid);
        check_field("fb_full", 32'd0, fb_full);
        drive_word(random_word());
        tick();
        push = 1'b0;
        check_packet(exp_q.pop_front());
        pop_one();
        finish_test("flush", errs);
    endtask

    task automatic test_decode_sweep();
        int errs;
        errs = errors;
        exp_q.delete();
        repeat (200) begin
            drive_word(random_word());
            tick();
            push = 1'b0;
            wait_valid("decode_sweep");
            check_packet(exp_q.pop_front());
            if (fb_valid === 1'b1) begin
                pop_one();
            end
        end
        finish_test("decode_sweep", errs);
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        instruction     = '0;
        pc              = '0;
        bp_tag          = '0;
        prediction_used = 1'b0;
        push            = 1'b0;
        flush           = 1'b0;
        pop             = 1'b0;
        buffer_reset    = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        buffer_reset = 1'b0;

        test_reset();
        test_single_push();
        test_back_pressure();
        test_push_pop_bypass();
        test_flush();
        test_decode_sweep();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/fetch_pkg.sv
verilog/fifo_if.sv
verilog/lutram_fifo.sv
verilog/instruction_predecoder.sv
verilog/pre_decode.sv
verilog/fetch_buffer_top.sv
test/tb_fetch_buffer.sv
